// File: tests/stack_core_tests.txt
// op imm result z_flag s_flag depth stk_err, all hex; op 0 push, 1 add, 2 sub
// alu ops take op1 from tos after the first pop and op2 from tos after the second
0 05 05 0 0 1 0
0 05 05 0 0 2 0
0 0c 0c 0 0 3 0
2 00 00 1 0 2 0
0 09 09 1 0 3 0
1 01 05 0 0 2 0
0 7f 7f 0 0 3 0
0 01 01 0 0 4 0
0 22 22 0 0 5 0
1 01 80 0 1 4 0
0 30 30 0 1 5 0
0 10 10 0 1 6 0
0 44 44 0 1 7 0
2 00 20 0 0 6 0
2 00 50 0 0 5 0
1 01 ff 0 1 4 0
2 00 86 0 1 3 0
1 01 0a 0 0 2 0
2 00 fb 0 1 1 0
1 01 00 1 0 1 1
0 01 01 1 0 2 1
0 02 02 1 0 3 1
0 03 03 1 0 4 1
0 04 04 1 0 5 1
0 05 05 1 0 6 1
0 06 06 1 0 7 1
0 07 07 1 0 8 1
0 08 08 1 0 8 1
2 00 ff 0 1 7 1

// File: sources.f
hw/stack_pkg.sv
hw/stack_mem.sv
hw/stack_alu.sv
hw/stack_ctrl.sv
hw/stack_core.sv
tests/tb_clock.sv
tests/stack_core_sva.sv
tests/stack_core_tb.sv

// File: Makefile
# Verilator build and run for the stack core testbench

VERILATOR ?= verilator
TOP       ?= stack_core_tb
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FILELIST  ?= sources.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG) || [ $$status -ne 0 ]; then \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: tests/stack_core_tb.sv
`default_nettype none

module stack_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam string TEST_FILE    = "tests/stack_core_tests.txt";
    localparam time   CLK_PERIOD   = 20ns;
    localparam time   DRIVE_DLY    = 2ns;           // after the rising edge
    localparam int    RESET_CYCLES = 4;
    localparam int    WDOG_PER_LINE = 20;           // clock periods
    localparam int    WDOG_MARGIN  = 50;
    localparam int    MAX_LINES    = 40;
    localparam int    FIELDS       = 7;             // op imm result z s depth err

    logic                           clk;
    logic                           rstn;
    logic                           instr_valid;
    stack_pkg::instr_u              instr;
    logic                           busy;
    logic                           done;
    stack_pkg::data_t               result;
    logic                           z_flag;
    logic                           s_flag;
    logic [stack_pkg::DEPTH_W-1:0]  depth;
    logic                           stk_err;

    logic [7:0] vec [MAX_LINES*FIELDS];
    int         n_lines = 0;
    int         n_checks;
    int         n_errors;

    tb_clock i_clock (.clk(clk));

    stack_core i_dut
    (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .busy        (busy),
        .done        (done),
        .result      (result),
        .z_flag      (z_flag),
        .s_flag      (s_flag),
        .depth       (depth),
        .stk_err     (stk_err)
    );

    bind stack_core stack_core_sva i_sva
    (
        .clk     (clk),
        .rstn    (rstn),
        .busy    (busy),
        .done    (done),
        .stk_req (stk_req)
    );

    task automatic check_value(input int line, input string name,
                               input logic [7:0] actual, input logic [7:0] expected);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("error: line %0d %s = 0x%02h, expected 0x%02h",
                     line, name, actual, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one instruction: strobe, wait for done, compare
    task automatic run_line(input int line);
        int base;
        base = line * FIELDS;
        @(posedge clk);
        #DRIVE_DLY;
        instr.push.op  = stack_pkg::op_e'(vec[base][1:0]);
        instr.push.imm = vec[base+1];               // low bit is asn for alu ops
        instr_valid    = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        instr_valid = 1'b0;
        check_value(line, "busy", 8'(busy), 8'h01); // raised by the strobe edge
        while (!done)
        begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_value(line, "busy", 8'(busy), 8'h00); // released with done
        check_value(line, "result", result, vec[base+2]);
        check_value(line, "z_flag", 8'(z_flag), vec[base+3]);
        check_value(line, "s_flag", 8'(s_flag), vec[base+4]);
        check_value(line, "depth", 8'(depth), vec[base+5]);
        check_value(line, "stk_err", 8'(stk_err), vec[base+6]);
    endtask

    initial
    begin
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        n_checks    = 0;
        n_errors    = 0;
        for (int i = 0; i < MAX_LINES*FIELDS; i++)
            vec[i] = 8'hff;                         // op ff marks the end
        $readmemh(TEST_FILE, vec);
        while (n_lines < MAX_LINES && vec[n_lines*FIELDS] != 8'hff)
            n_lines++;

        if (n_lines == 0)
        begin
            $display("no test lines could be read from %s", TEST_FILE);
            n_errors++;
        end
        else
        begin
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DLY;
            rstn = 1'b1;
            for (int i = 0; i < n_lines; i++)
                run_line(i);
        end

        $display("%0d lines, %0d checks, %0d errors", n_lines, n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // watchdog
    initial
    begin
        wait (n_lines > 0);
        #((n_lines * WDOG_PER_LINE + WDOG_MARGIN) * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clock periods",
                 n_lines * WDOG_PER_LINE + WDOG_MARGIN);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/stack_core_sva.sv
`default_nettype none

module stack_core_sva
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    busy,
    input  logic                    done,
    input  stack_pkg::stk_port_t    stk_req
);

    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake pulses
    done_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
        else $error("done stayed high for two cycles");

    // busy drops in the same cycle that done rises
    done_after_busy: assert property (@(posedge clk) disable iff (!rstn)
        done |-> $past(busy))
        else $error("done came without a busy cycle before it");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stack port
    push_pop_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(stk_req.push && stk_req.pop))
        else $error("push and pop requested together on the stack port");

    // first cycle out of reset, nothing in flight
    idle_after_reset: assert property (@(posedge clk)
        $rose(rstn) |-> (!busy && !done))
        else $error("busy or done high right after reset");

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock
(
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam time HALF_PERIOD = 10ns;                 // 20 ns clock

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// File: hw/stack_core.sv
`default_nettype none

module stack_core
(
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            instr_valid,
    input  stack_pkg::instr_u               instr,
    output logic                            busy,
    output logic                            done,
    output stack_pkg::data_t                result,
    output logic                            z_flag,
    output logic                            s_flag,
    output logic [stack_pkg::DEPTH_W-1:0]   depth,
    output logic                            stk_err
);

    logic                 alu_start;
    logic                 alu_asn;
    logic                 alu_fin;
    stack_pkg::stk_port_t alu_req;
    stack_pkg::stk_port_t stk_req;                  // muxed request into the stack
    stack_pkg::data_t     tos;

    stack_ctrl i_ctrl
    (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .alu_req     (alu_req),
        .alu_fin     (alu_fin),
        .alu_start   (alu_start),
        .alu_asn     (alu_asn),
        .stk_req     (stk_req),
        .busy        (busy),
        .done        (done),
        .result      (result)
    );

    stack_alu i_alu
    (
        .clk    (clk),
        .rstn   (rstn),
        .start  (alu_start),
        .asn    (alu_asn),
        .tos    (tos),
        .req    (alu_req),
        .z_flag (z_flag),
        .s_flag (s_flag),
        .fin    (alu_fin)
    );

    stack_mem i_mem
    (
        .clk     (clk),
        .rstn    (rstn),
        .req     (stk_req),
        .tos     (tos),
        .depth   (depth),
        .stk_err (stk_err)
    );

endmodule

`default_nettype wire

// File: hw/stack_ctrl.sv
`default_nettype none

module stack_ctrl
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    instr_valid,
    input  stack_pkg::instr_u       instr,
    input  stack_pkg::stk_port_t    alu_req,
    input  logic                    alu_fin,
    output logic                    alu_start,
    output logic                    alu_asn,
    output stack_pkg::stk_port_t    stk_req,
    output logic                    busy,
    output logic                    done,
    output stack_pkg::data_t        result
);

    stack_pkg::stk_port_t own_req;                  // immediate push request
    logic                 accept;
    logic                 is_push;
    logic                 is_alu;
    logic                 alu_active;
    logic                 push_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    assign accept    = instr_valid && !busy;
    assign is_push   = (instr.push.op == stack_pkg::OP_PUSH);
    assign is_alu    = (instr.push.op == stack_pkg::OP_ADD)
                    || (instr.push.op == stack_pkg::OP_SUB);
    assign alu_start = accept && is_alu;            // same cycle as the strobe
    assign alu_asn   = instr.alu.asn;

    // stack port goes to the alu for the length of its op
    assign stk_req = alu_active ? alu_req : own_req;

    assign busy = own_req.push || (alu_active && !alu_fin);
    assign done = push_done || alu_fin;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            own_req    <= '0;
            push_done  <= 1'b0;
            alu_active <= 1'b0;
            result     <= '0;
        end
        else
        begin
            own_req.push <= accept && is_push;
            own_req.pop  <= 1'b0;                   // never pops by itself
            if (accept && is_push)
                own_req.wdata <= instr.push.imm;
            push_done <= own_req.push;

            if (alu_start)
                alu_active <= 1'b1;
            else if (alu_fin)
                alu_active <= 1'b0;

            if (stk_req.push)
                result <= stk_req.wdata;            // last value sent to the stack
        end
    end

endmodule

`default_nettype wire

// File: hw/stack_alu.sv
`default_nettype none

module stack_alu
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    start,
    input  logic                    asn,
    input  stack_pkg::data_t        tos,
    output stack_pkg::stk_port_t    req,
    output logic                    z_flag,
    output logic                    s_flag,
    output logic                    fin
);

    typedef enum logic [3:0]
    {
        INIT    = 4'd0,
        OP1_POP = 4'd1,
        OP1_RCV = 4'd2,
        OP1_STR = 4'd3,
        OP2_POP = 4'd4,
        OP2_RCV = 4'd5,
        OP2_STR = 4'd6,
        ALU     = 4'd7,
        PUSH    = 4'd8,
        PUSH_D  = 4'd9
    } state_e;

    state_e           state;
    logic             add_sel;                      // asn held for the whole op
    stack_pkg::data_t op1;
    stack_pkg::data_t op2;
    stack_pkg::data_t res;

    // operands and result
    always_ff @(posedge clk)
    begin
        if (state == INIT && start)
            add_sel <= asn;
        if (state == OP1_STR)
            op1 <= tos;
        if (state == OP2_STR)
            op2 <= tos;
        if (state == ALU)
            res <= add_sel ? (op2 + op1) : (op2 - op1);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state  <= INIT;
            req    <= '0;
            z_flag <= 1'b0;
            s_flag <= 1'b0;
            fin    <= 1'b0;
        end
        else
        begin
            case (state)
                INIT:
                begin
                    fin <= 1'b0;
                    if (start)
                        state <= OP1_POP;
                end
                OP1_POP:
                begin
                    req.pop <= 1'b1;
                    state   <= OP1_RCV;
                end
                OP1_RCV:
                begin
                    req.pop <= 1'b0;                // tos valid next cycle
                    state   <= OP1_STR;
                end
                OP1_STR: state <= OP2_POP;
                OP2_POP:
                begin
                    req.pop <= 1'b1;
                    state   <= OP2_RCV;
                end
                OP2_RCV:
                begin
                    req.pop <= 1'b0;
                    state   <= OP2_STR;
                end
                OP2_STR: state <= ALU;
                ALU:     state <= PUSH;
                PUSH:
                begin
                    s_flag    <= (res < 0);
                    z_flag    <= (res == 0);
                    req.push  <= 1'b1;
                    req.wdata <= res;
                    state     <= PUSH_D;
                end
                PUSH_D:
                begin
                    req.push <= 1'b0;
                    fin      <= 1'b1;
                    state    <= INIT;
                end
                default: state <= INIT;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/stack_mem.sv
`default_nettype none

module stack_mem
(
    input  logic                            clk,
    input  logic                            rstn,
    input  stack_pkg::stk_port_t            req,
    output stack_pkg::data_t                tos,
    output logic [stack_pkg::DEPTH_W-1:0]   depth,
    output logic                            stk_err
);

    stack_pkg::data_t mem [stack_pkg::STACK_DEPTH];

    logic [$clog2(stack_pkg::STACK_DEPTH)-1:0] wr_ptr;     // first free slot
    logic [$clog2(stack_pkg::STACK_DEPTH)-1:0] nx_ptr;     // new top after a pop
    logic full;
    logic empty;

    assign wr_ptr = depth[$clog2(stack_pkg::STACK_DEPTH)-1:0];
    assign nx_ptr = wr_ptr - 2'd2;
    assign full   = (depth == stack_pkg::DEPTH_W'(stack_pkg::STACK_DEPTH));
    assign empty  = (depth == '0);

    always_ff @(posedge clk)
    begin
        if (req.push && !full)
            mem[wr_ptr] <= req.wdata;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointer, top of stack and error
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            depth   <= '0;
            tos     <= '0;
            stk_err <= 1'b0;
        end
        else if (req.push)
        begin
            if (full)
                stk_err <= 1'b1;                    // overflow, value dropped
            else
            begin
                depth <= depth + 1'b1;
                tos   <= req.wdata;
            end
        end
        else if (req.pop)
        begin
            if (empty)
            begin
                stk_err <= 1'b1;                    // underflow
                tos     <= '0;
            end
            else
            begin
                depth <= depth - 1'b1;
                tos   <= (depth == 1) ? '0 : mem[nx_ptr];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/stack_pkg.sv
`default_nettype none

package stack_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    localparam int DATA_LEN    = 8;
    localparam int STACK_DEPTH = 8;
    localparam int DEPTH_W     = 4;                 // holds 0..STACK_DEPTH

    typedef logic signed [DATA_LEN-1:0] data_t;

    typedef enum logic [1:0]
    {
        OP_PUSH = 2'b00,
        OP_ADD  = 2'b01,
        OP_SUB  = 2'b10
    } op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction word, read as push or as alu op
    typedef struct packed
    {
        op_e   op;
        data_t imm;                                 // value to push
    } push_view_t;

    // for OP_ADD and OP_SUB the low bit selects the operation
    typedef struct packed
    {
        op_e        op;
        logic [6:0] unused;
        logic       asn;                            // 1 add, 0 subtract
    } alu_view_t;

    typedef union packed
    {
        push_view_t push;
        alu_view_t  alu;
    } instr_u;

    // one requester's view of the stack
    typedef struct packed
    {
        logic  push;
        logic  pop;
        data_t wdata;
    } stk_port_t;

endpackage

`default_nettype wire
